//--- rtl/core_pkg.sv
package core_pkg;

  localparam int XLEN = 64;
  localparam logic [XLEN-1:0] RESET_PC = 64'h8000_0000;

  // major opcodes, inst[6:0]
  typedef enum logic [6:0] {
    OP_IMM = 7'b0010011,
    OP     = 7'b0110011,
    LUI    = 7'b0110111,
    AUIPC  = 7'b0010111,
    JAL    = 7'b1101111,
    JALR   = 7'b1100111,
    BRANCH = 7'b1100011,
    LOAD   = 7'b0000011,
    STORE  = 7'b0100011,
    SYSTEM = 7'b1110011
  } opcode_e;

  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLL    = 3'd5,
    ALU_PASS_B = 3'd6  // lui, operand b straight through
  } alu_op_e;

  typedef enum logic [1:0] {
    CSR_NONE  = 2'd0,
    CSR_RW    = 2'd1,
    CSR_ECALL = 2'd2,
    CSR_MRET  = 2'd3
  } csr_cmd_e;

  // write-back source
  typedef enum logic [1:0] {
    WB_ALU  = 2'd0,
    WB_LOAD = 2'd1,
    WB_LINK = 2'd2,  // pc + 4 for jal/jalr
    WB_CSR  = 2'd3
  } wb_sel_e;

  // machine CSR addresses
  localparam logic [11:0] CSR_MSTATUS = 12'h300;
  localparam logic [11:0] CSR_MTVEC   = 12'h305;
  localparam logic [11:0] CSR_MEPC    = 12'h341;
  localparam logic [11:0] CSR_MCAUSE  = 12'h342;

  localparam logic [11:0] FUNCT12_MRET = 12'h302;

  // environment call from m-mode
  localparam logic [XLEN-1:0] CAUSE_ECALL_M = 64'd11;

endpackage

//--- rtl/core_fetch.sv
`timescale 1ns/10ps

module core_fetch (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic                      redirect_i,
  input  logic [core_pkg::XLEN-1:0] redirect_pc_i,
  output logic [core_pkg::XLEN-1:0] pc_o
);
  import core_pkg::*;

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_next;

  // sequential fetch unless told otherwise
  always_comb begin
    if (redirect_i) begin
      pc_next = redirect_pc_i;
    end else begin
      pc_next = pc_q + 64'd4;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;  // also the imem address

endmodule

//--- rtl/core_decode.sv
`timescale 1ns/10ps

module core_decode (
  input  logic [31:0]               inst_i,
  input  logic [core_pkg::XLEN-1:0] pc_i,
  input  logic [core_pkg::XLEN-1:0] rs1_data_i,
  input  logic [core_pkg::XLEN-1:0] rs2_data_i,
  output logic [4:0]                rs1_addr_o,
  output logic [4:0]                rs2_addr_o,
  output logic [core_pkg::XLEN-1:0] op_a_o,
  output logic [core_pkg::XLEN-1:0] op_b_o,
  output logic [core_pkg::XLEN-1:0] store_data_o,
  output core_pkg::alu_op_e         alu_op_o,
  output core_pkg::wb_sel_e         wb_sel_o,
  output logic                      rd_we_o,
  output logic [4:0]                rd_addr_o,
  output logic                      mem_we_o,
  output logic                      mem_re_o,
  output core_pkg::csr_cmd_e        csr_cmd_o,
  output logic [11:0]               csr_addr_o,
  output logic                      jump_o,
  output logic [core_pkg::XLEN-1:0] jump_target_o
);
  import core_pkg::*;

  opcode_e         opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [XLEN-1:0] imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [XLEN-1:0] jalr_sum;
  logic            rd_we;

  assign opcode = opcode_e'(inst_i[6:0]);
  assign funct3 = inst_i[14:12];
  assign funct7 = inst_i[31:25];

  assign imm_i = {{52{inst_i[31]}}, inst_i[31:20]};
  assign imm_s = {{52{inst_i[31]}}, inst_i[31:25], inst_i[11:7]};
  assign imm_b = {{51{inst_i[31]}}, inst_i[31], inst_i[7], inst_i[30:25], inst_i[11:8], 1'b0};
  assign imm_u = {{32{inst_i[31]}}, inst_i[31:12], 12'b0};
  assign imm_j = {{43{inst_i[31]}}, inst_i[31], inst_i[19:12], inst_i[20], inst_i[30:21], 1'b0};

  assign rs1_addr_o   = inst_i[19:15];
  assign rs2_addr_o   = inst_i[24:20];
  assign rd_addr_o    = inst_i[11:7];
  assign csr_addr_o   = inst_i[31:20];
  assign store_data_o = rs2_data_i;
  assign jalr_sum     = rs1_data_i + imm_i;

  always_comb begin
    op_a_o        = rs1_data_i;
    op_b_o        = imm_i;
    alu_op_o      = ALU_ADD;
    wb_sel_o      = WB_ALU;
    rd_we         = 1'b0;
    mem_we_o      = 1'b0;
    mem_re_o      = 1'b0;
    csr_cmd_o     = CSR_NONE;
    jump_o        = 1'b0;
    jump_target_o = pc_i + imm_b;
    case (opcode)
      OP_IMM: begin
        rd_we = 1'b1;
        case (funct3)
          3'b000: alu_op_o = ALU_ADD;
          3'b100: alu_op_o = ALU_XOR;
          3'b110: alu_op_o = ALU_OR;
          3'b111: alu_op_o = ALU_AND;
          3'b001: begin
            alu_op_o = ALU_SLL;
            rd_we    = (inst_i[31:26] == 6'b0);  // shamt is 6 bits on rv64
          end
          default: rd_we = 1'b0;
        endcase
      end
      OP: begin
        op_b_o = rs2_data_i;
        rd_we  = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: alu_op_o = ALU_ADD;
          10'b0100000_000: alu_op_o = ALU_SUB;
          10'b0000000_100: alu_op_o = ALU_XOR;
          10'b0000000_110: alu_op_o = ALU_OR;
          10'b0000000_111: alu_op_o = ALU_AND;
          default:         rd_we    = 1'b0;
        endcase
      end
      LUI: begin
        op_b_o   = imm_u;
        alu_op_o = ALU_PASS_B;
        rd_we    = 1'b1;
      end
      AUIPC: begin
        op_a_o = pc_i;
        op_b_o = imm_u;
        rd_we  = 1'b1;
      end
      JAL: begin
        wb_sel_o      = WB_LINK;
        rd_we         = 1'b1;
        jump_o        = 1'b1;
        jump_target_o = pc_i + imm_j;
      end
      JALR: begin
        if (funct3 == 3'b000) begin
          wb_sel_o      = WB_LINK;
          rd_we         = 1'b1;
          jump_o        = 1'b1;
          jump_target_o = {jalr_sum[XLEN-1:1], 1'b0};
        end
      end
      BRANCH: begin
        if (funct3 == 3'b000) begin
          jump_o = (rs1_data_i == rs2_data_i);  // beq
        end else if (funct3 == 3'b001) begin
          jump_o = (rs1_data_i != rs2_data_i);  // bne
        end
      end
      LOAD: begin
        if (funct3 == 3'b011) begin  // ld only
          mem_re_o = 1'b1;
          wb_sel_o = WB_LOAD;
          rd_we    = 1'b1;
        end
      end
      STORE: begin
        op_b_o   = imm_s;
        mem_we_o = (funct3 == 3'b011);  // sd only
      end
      SYSTEM: begin
        if (funct3 == 3'b001) begin
          csr_cmd_o = CSR_RW;
          wb_sel_o  = WB_CSR;
          rd_we     = 1'b1;
        end else if (inst_i[31:7] == 25'b0) begin
          csr_cmd_o = CSR_ECALL;
        end else if (inst_i[31:7] == {FUNCT12_MRET, 13'b0}) begin
          csr_cmd_o = CSR_MRET;
        end
      end
      default: rd_we = 1'b0;  // unknown encoding, no-op
    endcase
  end

  assign rd_we_o = rd_we && (rd_addr_o != 5'd0);  // x0 writes dropped here

endmodule

//--- rtl/core_regfile.sv
`timescale 1ns/10ps

module core_regfile (
  input  logic                      clk,
  input  logic [4:0]                rs1_addr_i,
  input  logic [4:0]                rs2_addr_i,
  output logic [core_pkg::XLEN-1:0] rs1_data_o,
  output logic [core_pkg::XLEN-1:0] rs2_data_o,
  input  logic                      we_i,
  input  logic [4:0]                rd_addr_i,
  input  logic [core_pkg::XLEN-1:0] rd_data_i
);
  import core_pkg::*;

  logic [XLEN-1:0] regs_q [32];  // entry 0 never written

  // x0 reads as zero
  always_comb begin
    if (rs1_addr_i == 5'd0) begin
      rs1_data_o = '0;
    end else begin
      rs1_data_o = regs_q[rs1_addr_i];
    end
    if (rs2_addr_i == 5'd0) begin
      rs2_data_o = '0;
    end else begin
      rs2_data_o = regs_q[rs2_addr_i];
    end
  end

  always_ff @(posedge clk) begin
    if (we_i && (rd_addr_i != 5'd0)) begin
      regs_q[rd_addr_i] <= rd_data_i;
    end
  end

endmodule

//--- rtl/core_csr.sv
`timescale 1ns/10ps

module core_csr (
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [core_pkg::XLEN-1:0] pc_i,
  input  core_pkg::csr_cmd_e        cmd_i,
  input  logic [11:0]               addr_i,
  input  logic [core_pkg::XLEN-1:0] wdata_i,
  output logic [core_pkg::XLEN-1:0] rdata_o,
  output logic                      redirect_o,
  output logic [core_pkg::XLEN-1:0] redirect_pc_o
);
  import core_pkg::*;

  logic [XLEN-1:0] mstatus_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mcause_q;

  always_comb begin
    case (addr_i)
      CSR_MSTATUS: rdata_o = mstatus_q;
      CSR_MTVEC:   rdata_o = mtvec_q;
      CSR_MEPC:    rdata_o = mepc_q;
      CSR_MCAUSE:  rdata_o = mcause_q;
      default:     rdata_o = '0;  // unimplemented
    endcase
  end

  assign redirect_o    = (cmd_i == CSR_ECALL) || (cmd_i == CSR_MRET);
  assign redirect_pc_o = (cmd_i == CSR_MRET) ? mepc_q : {mtvec_q[XLEN-1:2], 2'b00};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mstatus_q <= '0;
      mtvec_q   <= '0;
      mepc_q    <= '0;
      mcause_q  <= '0;
    end else begin
      case (cmd_i)
        CSR_RW: begin
          case (addr_i)
            CSR_MSTATUS: mstatus_q <= wdata_i;
            CSR_MTVEC:   mtvec_q   <= wdata_i;
            CSR_MEPC:    mepc_q    <= wdata_i;
            CSR_MCAUSE:  mcause_q  <= wdata_i;
            default:     ;
          endcase
        end
        CSR_ECALL: begin
          mepc_q   <= pc_i;  // pc of the ecall itself
          mcause_q <= CAUSE_ECALL_M;
        end
        default: ;
      endcase
    end
  end

endmodule

//--- rtl/core_execute.sv
`timescale 1ns/10ps

module core_execute (
  input  logic                      valid_i,
  input  logic [core_pkg::XLEN-1:0] op_a_i,
  input  logic [core_pkg::XLEN-1:0] op_b_i,
  input  logic [core_pkg::XLEN-1:0] store_data_i,
  input  core_pkg::alu_op_e         alu_op_i,
  input  core_pkg::wb_sel_e         wb_sel_i,
  input  logic [core_pkg::XLEN-1:0] pc_i,
  input  logic [core_pkg::XLEN-1:0] csr_rdata_i,
  input  logic                      mem_we_i,
  input  logic                      mem_re_i,
  output logic [core_pkg::XLEN-1:0] dmem_addr_o,
  output logic                      dmem_we_o,
  output logic                      dmem_re_o,
  output logic [core_pkg::XLEN-1:0] dmem_wdata_o,
  input  logic [core_pkg::XLEN-1:0] dmem_rdata_i,
  output logic [core_pkg::XLEN-1:0] wb_data_o
);
  import core_pkg::*;

  logic [XLEN-1:0] alu_res;

  always_comb begin
    case (alu_op_i)
      ALU_ADD:    alu_res = op_a_i + op_b_i;
      ALU_SUB:    alu_res = op_a_i - op_b_i;
      ALU_AND:    alu_res = op_a_i & op_b_i;
      ALU_OR:     alu_res = op_a_i | op_b_i;
      ALU_XOR:    alu_res = op_a_i ^ op_b_i;
      ALU_SLL:    alu_res = op_a_i << op_b_i[5:0];
      ALU_PASS_B: alu_res = op_b_i;
      default:    alu_res = op_a_i + op_b_i;
    endcase
  end

  // ld/sd address is the adder output
  assign dmem_addr_o  = alu_res;
  assign dmem_wdata_o = store_data_i;
  assign dmem_we_o    = mem_we_i && valid_i;  // quiet while held in reset
  assign dmem_re_o    = mem_re_i && valid_i;

  always_comb begin
    case (wb_sel_i)
      WB_ALU:  wb_data_o = alu_res;
      WB_LOAD: wb_data_o = dmem_rdata_i;
      WB_LINK: wb_data_o = pc_i + 64'd4;
      WB_CSR:  wb_data_o = csr_rdata_i;  // old csr value
      default: wb_data_o = alu_res;
    endcase
  end

endmodule

//--- rtl/core_top.sv
`timescale 1ns/10ps

module core_top (
  input  logic                      clk,
  input  logic                      rst_n,
  output logic [core_pkg::XLEN-1:0] imem_addr_o,
  input  logic [31:0]               imem_data_i,
  output logic [core_pkg::XLEN-1:0] dmem_addr_o,
  output logic                      dmem_we_o,
  output logic                      dmem_re_o,
  output logic [core_pkg::XLEN-1:0] dmem_wdata_o,
  input  logic [core_pkg::XLEN-1:0] dmem_rdata_i,
  output logic                      retire_valid_o,
  output logic [core_pkg::XLEN-1:0] retire_pc_o,
  output logic                      retire_we_o,
  output logic [4:0]                retire_rd_o,
  output logic [core_pkg::XLEN-1:0] retire_wdata_o
);
  import core_pkg::*;

  logic            valid_q;  // core running, one cycle behind reset release
  logic [XLEN-1:0] pc;
  logic [4:0]      rs1_addr, rs2_addr, rd_addr;
  logic [XLEN-1:0] rs1_data, rs2_data;
  logic [XLEN-1:0] op_a, op_b, store_data, jump_target;
  alu_op_e         alu_op;
  wb_sel_e         wb_sel;
  csr_cmd_e        csr_cmd, csr_cmd_gated;
  logic [11:0]     csr_addr;
  logic            rd_we, rf_we, mem_we, mem_re, jump;
  logic [XLEN-1:0] csr_rdata, csr_redirect_pc, wb_data;
  logic            csr_redirect, redirect;
  logic [XLEN-1:0] redirect_pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b1;
    end
  end

  // trap/mret beats jump, pc held until the first valid cycle
  assign csr_cmd_gated = valid_q ? csr_cmd : CSR_NONE;
  assign redirect      = !valid_q || csr_redirect || jump;
  assign redirect_pc   = !valid_q ? pc : (csr_redirect ? csr_redirect_pc : jump_target);
  assign rf_we         = rd_we && valid_q;

  core_fetch u_fetch (
    .clk(clk), .rst_n(rst_n), .redirect_i(redirect), .redirect_pc_i(redirect_pc), .pc_o(pc)
  );

  core_decode u_decode (
    .inst_i(imem_data_i), .pc_i(pc), .rs1_data_i(rs1_data), .rs2_data_i(rs2_data),
    .rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .op_a_o(op_a), .op_b_o(op_b),
    .store_data_o(store_data), .alu_op_o(alu_op), .wb_sel_o(wb_sel), .rd_we_o(rd_we),
    .rd_addr_o(rd_addr), .mem_we_o(mem_we), .mem_re_o(mem_re), .csr_cmd_o(csr_cmd),
    .csr_addr_o(csr_addr), .jump_o(jump), .jump_target_o(jump_target)
  );

  core_regfile u_regfile (
    .clk(clk), .rs1_addr_i(rs1_addr), .rs2_addr_i(rs2_addr), .rs1_data_o(rs1_data),
    .rs2_data_o(rs2_data), .we_i(rf_we), .rd_addr_i(rd_addr), .rd_data_i(wb_data)
  );

  core_csr u_csr (
    .clk(clk), .rst_n(rst_n), .pc_i(pc), .cmd_i(csr_cmd_gated), .addr_i(csr_addr),
    .wdata_i(rs1_data), .rdata_o(csr_rdata), .redirect_o(csr_redirect),
    .redirect_pc_o(csr_redirect_pc)
  );

  core_execute u_execute (
    .valid_i(valid_q), .op_a_i(op_a), .op_b_i(op_b), .store_data_i(store_data),
    .alu_op_i(alu_op), .wb_sel_i(wb_sel), .pc_i(pc), .csr_rdata_i(csr_rdata),
    .mem_we_i(mem_we), .mem_re_i(mem_re), .dmem_addr_o(dmem_addr_o), .dmem_we_o(dmem_we_o),
    .dmem_re_o(dmem_re_o), .dmem_wdata_o(dmem_wdata_o), .dmem_rdata_i(dmem_rdata_i),
    .wb_data_o(wb_data)
  );

  assign imem_addr_o    = pc;
  assign retire_valid_o = valid_q;
  assign retire_pc_o    = pc;
  assign retire_we_o    = rf_we;
  assign retire_rd_o    = rd_addr;
  assign retire_wdata_o = wb_data;

endmodule

//--- dv/core_assertions.sv
`timescale 1ns/10ps

module core_assertions (
  input logic                      clk_i,
  input logic                      rst_n_i,
  input logic                      valid_i,
  input logic                      dmem_we_i,
  input logic                      dmem_re_i,
  input logic                      retire_we_i,
  input logic [4:0]                retire_rd_i,
  input core_pkg::csr_cmd_e        csr_cmd_i,
  input logic [core_pkg::XLEN-1:0] mtvec_i,
  input logic [core_pkg::XLEN-1:0] pc_i
);
  import core_pkg::*;

  a_strobes_exclusive: assert property (@(posedge clk_i) !(dmem_we_i && dmem_re_i))
    else $error("dmem read and write strobes high together");

  a_no_x0_write: assert property (@(posedge clk_i) retire_we_i |-> retire_rd_i != 5'd0)
    else $error("retire port reports a write to x0");

  // trap target is mtvec with the low bits cleared
  a_ecall_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (valid_i && csr_cmd_i == CSR_ECALL) |=> pc_i == {$past(mtvec_i[XLEN-1:2]), 2'b00})
    else $error("pc after ecall is not the trap vector");

  a_reset_quiet: assert property (@(posedge clk_i) !rst_n_i |-> !dmem_we_i && !dmem_re_i)
    else $error("memory strobe active during reset");

endmodule

bind core_top core_assertions u_assertions (
  .clk_i(clk), .rst_n_i(rst_n), .valid_i(valid_q), .dmem_we_i(dmem_we_o),
  .dmem_re_i(dmem_re_o), .retire_we_i(retire_we_o), .retire_rd_i(retire_rd_o),
  .csr_cmd_i(csr_cmd_gated), .mtvec_i(u_csr.mtvec_q), .pc_i(pc)
);

//--- dv/core_tb.sv
`timescale 1ns/10ps

module core_tb;
  import core_pkg::*;

  localparam int NUM_INIT  = 31;    // addi x1..x31 from x0 first
  localparam int NUM_INSTR = 4000;
  localparam int PERIOD    = 4;

  logic            clk = 1'b0;
  logic            rst_n;
  logic [63:0]     imem_addr, dmem_addr, dmem_wdata, dmem_rdata, retire_pc, retire_wdata;
  logic [31:0]     imem_data;
  logic            dmem_we, dmem_re, retire_valid, retire_we;
  logic [4:0]      retire_rd;

  logic [31:0]     lfsr_q;
  logic [63:0]     m_pc;
  logic [63:0]     m_regs [32];
  logic [63:0]     m_csr [4];  // mstatus, mtvec, mepc, mcause
  logic [63:0]     m_mem [logic [60:0]];  // keyed by doubleword address
  int              instr_cnt;

  core_top dut_i (
    .clk(clk), .rst_n(rst_n), .imem_addr_o(imem_addr), .imem_data_i(imem_data),
    .dmem_addr_o(dmem_addr), .dmem_we_o(dmem_we), .dmem_re_o(dmem_re),
    .dmem_wdata_o(dmem_wdata), .dmem_rdata_i(dmem_rdata), .retire_valid_o(retire_valid),
    .retire_pc_o(retire_pc), .retire_we_o(retire_we), .retire_rd_o(retire_rd),
    .retire_wdata_o(retire_wdata)
  );

  initial begin
    forever #(PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((NUM_INIT + NUM_INSTR + 8 + 50) * PERIOD);
    $display("Verification failed");
    $fatal(1, "watchdog timeout, the core did not get through all instructions in time");
  end

  // fibonacci lfsr with taps 32 22 2 1
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        fb;
    val = '0;
    for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      val    = {val[30:0], fb};
    end
    return val;
  endfunction

  function automatic logic [63:0] mem_read(input logic [63:0] addr);
    if (m_mem.exists(addr[63:3])) begin
      return m_mem[addr[63:3]];
    end
    return {addr[63:3], 3'b000} ^ 64'hc3a5_5a3c_0f1e_e1f0;  // unwritten fill
  endfunction

  function automatic int csr_index(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS: return 0;
      CSR_MTVEC:   return 1;
      CSR_MEPC:    return 2;
      CSR_MCAUSE:  return 3;
      default:     return -1;
    endcase
  endfunction

  function automatic logic [31:0] itype(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input opcode_e op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] rtype(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OP};
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("** Error: %s (instruction %0d) expected %h actual %h",
               name, instr_cnt, exp, act);
      $display("Verification failed");
      $fatal(1, "mismatch between model and core");
    end
  endtask

  task automatic run_instruction(input bit init, input int idx);
    logic [31:0] inst;
    logic [3:0]  kind;
    logic [4:0]  rd, rs1, rs2;
    logic [11:0] imm12, caddr;
    logic [19:0] u20;
    logic [63:0] a, b, imm, off, t, next_pc, wd, maddr, mwdata;
    logic        we, mwe, mre;
    int          ci;
    string       name;
    rd    = 5'(take_bits(5));
    rs1   = 5'(take_bits(5));
    rs2   = 5'(take_bits(5));
    imm12 = 12'(take_bits(12));
    u20   = 20'(take_bits(20));
    kind  = init ? 4'd0 : 4'(take_bits(4));
    if (init) begin
      rd  = 5'(idx + 1);
      rs1 = 5'd0;
    end
    if ((kind == 4'd12 || kind == 4'd13) && imm12[10]) rs1 = 5'd0;  // low addresses collide
    if (kind == 4'd11 && imm12[7]) rs2 = rs1;  // so beq gets taken too
    a = m_regs[rs1];
    b = m_regs[rs2];
    imm = {{52{imm12[11]}}, imm12};
    next_pc = m_pc + 64'd4;
    {we, mwe, mre} = 3'b000;
    {wd, maddr, mwdata} = '0;
    ci = -1;
    case (kind)
      4'd0: begin
        name = "addi";
        inst = itype(imm12, rs1, 3'b000, rd, OP_IMM);
        we   = 1;
        wd   = a + imm;
      end
      4'd1: begin
        name = "andi";
        inst = itype(imm12, rs1, 3'b111, rd, OP_IMM);
        we   = 1;
        wd   = a & imm;
      end
      4'd2: begin
        name = "ori";
        inst = itype(imm12, rs1, 3'b110, rd, OP_IMM);
        we   = 1;
        wd   = a | imm;
      end
      4'd3: begin
        name = "xori";
        inst = itype(imm12, rs1, 3'b100, rd, OP_IMM);
        we   = 1;
        wd   = a ^ imm;
      end
      4'd4: begin
        name = "slli";
        inst = itype({6'b0, imm12[5:0]}, rs1, 3'b001, rd, OP_IMM);
        we   = 1;
        wd   = a << imm12[5:0];
      end
      4'd5: begin
        name = imm12[0] ? "sub" : "add";
        inst = rtype(imm12[0] ? 7'b0100000 : 7'b0, rs2, rs1, 3'b000, rd);
        we   = 1;
        wd   = imm12[0] ? a - b : a + b;
      end
      4'd6: begin
        we = 1;
        if (imm12[0]) begin
          name = "xor";
          inst = rtype(7'b0, rs2, rs1, 3'b100, rd);
          wd   = a ^ b;
        end else if (imm12[1]) begin
          name = "or";
          inst = rtype(7'b0, rs2, rs1, 3'b110, rd);
          wd   = a | b;
        end else begin
          name = "and";
          inst = rtype(7'b0, rs2, rs1, 3'b111, rd);
          wd   = a & b;
        end
      end
      4'd7: begin
        name = "lui";
        inst = {u20, rd, LUI};
        we   = 1;
        wd   = {{32{u20[19]}}, u20, 12'b0};
      end
      4'd8: begin
        name = "auipc";
        inst = {u20, rd, AUIPC};
        we   = 1;
        wd   = m_pc + {{32{u20[19]}}, u20, 12'b0};
      end
      4'd9: begin
        name    = "jal";
        off     = {{54{imm12[7]}}, imm12[7:0], 2'b00};
        inst    = {off[20], off[10:1], off[11], off[19:12], rd, JAL};
        we      = 1;
        wd      = m_pc + 64'd4;
        next_pc = m_pc + off;
      end
      4'd10: begin
        name    = "jalr";
        imm12   = {imm12[11:2], 2'b00} - {10'b0, a[1:0]};  // keeps the target word aligned
        imm     = {{52{imm12[11]}}, imm12};
        inst    = itype(imm12, rs1, 3'b000, rd, JALR);
        t       = a + imm;
        we      = 1;
        wd      = m_pc + 64'd4;
        next_pc = {t[63:1], 1'b0};
      end
      4'd11: begin
        name = imm12[6] ? "bne" : "beq";
        off  = {{56{imm12[5]}}, imm12[5:0], 2'b00};
        inst = {off[12], off[10:5], rs2, rs1, 2'b00, imm12[6], off[4:1], off[11], BRANCH};
        if (imm12[6] ? (a != b) : (a == b)) next_pc = m_pc + off;
      end
      4'd12: begin
        name  = "ld";
        inst  = itype(imm12, rs1, 3'b011, rd, LOAD);
        maddr = a + imm;
        mre   = 1;
        we    = 1;
        wd    = mem_read(maddr);
      end
      4'd13: begin
        name   = "sd";
        inst   = {imm12[11:5], rs2, rs1, 3'b011, imm12[4:0], STORE};
        maddr  = a + imm;
        mwe    = 1;
        mwdata = b;
      end
      4'd14: begin
        name  = "csrrw";
        caddr = (imm12[4:2] == 3'b0) ? 12'h7c0 :
                (imm12[1:0] == 2'd0) ? CSR_MSTATUS : (imm12[1:0] == 2'd1) ? CSR_MTVEC :
                (imm12[1:0] == 2'd2) ? CSR_MEPC : CSR_MCAUSE;
        ci    = csr_index(caddr);
        inst  = itype(caddr, rs1, 3'b001, rd, SYSTEM);
        we    = 1;
        wd    = (ci < 0) ? 64'd0 : m_csr[ci];
      end
      default: begin
        if (imm12[0]) begin
          name    = "mret";
          inst    = 32'h3020_0073;
          next_pc = m_csr[2];
        end else begin
          name    = "ecall";
          inst    = 32'h0000_0073;
          next_pc = {m_csr[1][63:2], 2'b00};
        end
      end
    endcase
    we = we && (rd != 5'd0);
    imem_data  = inst;
    dmem_rdata = mem_read(maddr);
    #1;  // outputs settle well before the rising edge
    check_value({name, " retire_valid"}, 64'd1, 64'(retire_valid));
    check_value({name, " pc"}, m_pc, imem_addr);
    check_value({name, " retire_pc"}, m_pc, retire_pc);
    check_value({name, " retire_we"}, 64'(we), 64'(retire_we));
    if (we) begin
      check_value({name, " retire_rd"}, 64'(rd), 64'(retire_rd));
      check_value({name, " retire_wdata"}, wd, retire_wdata);
    end
    check_value({name, " dmem_we"}, 64'(mwe), 64'(dmem_we));
    check_value({name, " dmem_re"}, 64'(mre), 64'(dmem_re));
    if (mwe || mre) check_value({name, " dmem_addr"}, maddr, dmem_addr);
    if (mwe) check_value({name, " dmem_wdata"}, mwdata, dmem_wdata);
    // commit into the model
    if (we) m_regs[rd] = wd;
    if (mwe) m_mem[maddr[63:3]] = mwdata;
    if (ci >= 0) m_csr[ci] = a;
    if (kind == 4'd15 && !imm12[0]) begin
      m_csr[2] = m_pc;
      m_csr[3] = CAUSE_ECALL_M;
    end
    m_pc = next_pc;
  endtask

  initial begin
    lfsr_q     = 32'hbf9c_d705;
    rst_n      = 1'b0;
    imem_data  = 32'h0000_0013;  // nop
    dmem_rdata = '0;
    instr_cnt  = 0;
    m_pc       = RESET_PC;
    for (int i = 0; i < 32; i++) m_regs[i] = '0;
    for (int i = 0; i < 4; i++) m_csr[i] = '0;
    repeat (8) @(negedge clk);
    check_value("reset retire_valid", 64'd0, 64'(retire_valid));
    check_value("reset dmem strobes", 64'd0, 64'({dmem_we, dmem_re}));
    check_value("reset pc", RESET_PC, imem_addr);
    rst_n = 1'b1;
    @(negedge clk);
    for (int i = 0; i < NUM_INIT + NUM_INSTR; i++) begin
      instr_cnt = i;
      run_instruction(i < NUM_INIT, i);
      @(negedge clk);
    end
    $display("Verification passed");
    $finish;
  end

endmodule

//--- project.f
rtl/core_pkg.sv
rtl/core_fetch.sv
rtl/core_decode.sv
rtl/core_regfile.sv
rtl/core_csr.sv
rtl/core_execute.sv
rtl/core_top.sv
dv/core_assertions.sv
dv/core_tb.sv

//--- run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --assert -j 0 --top-module core_tb -f project.f -o core_sim \
  && ./obj_dir/core_sim \
  || { echo "simulation run did not complete successfully"; exit 1; }
